//--- common/mcr3_input_pkg.sv
// Shared types and constants for the MCR3 input block; all control fields are active high, ports are active low
package mcr3_input_pkg;

	// ============================================================
	// Game selection
	// ============================================================

	typedef enum logic [1:0] {
		sarge       = 2'd0,
		max_rpm     = 2'd1,
		rampage     = 2'd2,
		power_drive = 2'd3
	} game_e;

	// ============================================================
	// Control inputs
	// ============================================================

	// One player's joystick and four buttons
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
		logic fire_c;
		logic fire_d;
	} player_t;

	// Cabinet buttons shared by all players
	typedef struct packed {
		logic coin1;
		logic coin2;
		logic coin3;
		logic start1;
		logic start2;
		logic service;
		logic tilt;
		logic spare;
	} cabinet_t;

	// ============================================================
	// CPU side ports
	// ============================================================

	// Input ports as the CPU reads them, active low
	typedef struct packed {
		logic [7:0] port0;
		logic [7:0] port1;
		logic [7:0] port2;
		logic [7:0] port3;
		logic [7:0] port4;
	} in_ports_t;

	// Output ports as last written by the CPU
	typedef struct packed {
		logic [7:0] port5;
		logic [7:0] port6;
	} out_latch_t;

	// Pedal and wheel positions for one player
	typedef struct packed {
		logic [7:0] gas;
		logic [7:0] steering;
	} analog_t;

	// Max RPM gears 0..4, Power Drive toggles one bit per player
	typedef struct packed {
		logic [2:0] gear1;
		logic [2:0] gear2;
		logic [2:0] pd_gear;
		logic [6:0] pad;
	} gear_state_t;

	// ============================================================
	// Constants
	// ============================================================

	// Shifter code seen by the game for gears 0..4, entry 0 is neutral
	localparam logic [4:0][3:0] gear_code = {4'h2, 4'h1, 4'h6, 4'h5, 4'h0};

	localparam logic [2:0] max_gear    = 3'd4;
	localparam logic [7:0] ramp_step   = 8'd8;
	localparam logic [7:0] gas_reset   = 8'h00;
	localparam logic [7:0] steer_reset = 8'h80;

endpackage

//--- analog_control/pedal_steer_ramp.sv
// Gas and steering move by ramp_step once per vsync rise while held; no auto-centring, up and right win ties
`timescale 1ns/1ps

module pedal_steer_ramp (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    vsync,
	input  mcr3_input_pkg::player_t ctrl,
	output mcr3_input_pkg::analog_t analog
);

	logic [1:0] vsync_d;
	logic       frame_tick;
	logic [7:0] gas;
	logic [7:0] steering;

	// Saturating steps toward 0xFF and 0x00
	function automatic logic [7:0] step_up(input logic [7:0] value);
		if (value > (8'hFF - mcr3_input_pkg::ramp_step)) begin
			return 8'hFF;
		end
		return value + mcr3_input_pkg::ramp_step;
	endfunction

	function automatic logic [7:0] step_down(input logic [7:0] value);
		if (value < mcr3_input_pkg::ramp_step) begin
			return 8'h00;
		end
		return value - mcr3_input_pkg::ramp_step;
	endfunction

	// vsync is sampled then delayed once more for the edge
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vsync_d <= 2'b00;
		end else begin
			vsync_d <= {vsync_d[0], vsync};
		end
	end

	assign frame_tick = vsync_d[0] & ~vsync_d[1];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gas      <= mcr3_input_pkg::gas_reset;
			steering <= mcr3_input_pkg::steer_reset;
		end else if (frame_tick) begin
			if (ctrl.up) begin
				gas <= step_up(gas);
			end else if (ctrl.down) begin
				gas <= step_down(gas);
			end
			if (ctrl.right) begin
				steering <= step_up(steering);
			end else if (ctrl.left) begin
				steering <= step_down(steering);
			end
		end
	end

	assign analog.gas      = gas;
	assign analog.steering = steering;

	// Values may only move on the cycle after a frame tick
	assert property (@(posedge clk_sys) disable iff (reset)
		!frame_tick |=> $stable(analog))
		else $error("analog value changed without a vsync edge");

endmodule

//--- analog_control/analog_select.sv
// ADC channel latch; the CPU selects while port6 bits 6 and 5 are both low, output is combinational
`timescale 1ns/1ps

module analog_select (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  mcr3_input_pkg::out_latch_t cpu_out,
	input  mcr3_input_pkg::analog_t    pl1,
	input  mcr3_input_pkg::analog_t    pl2,
	output logic [7:0]                 analog_byte
);

	logic [1:0] adc_sel;
	logic       sel_strobe;

	// Both chip selects low means a write to the ADC mux
	assign sel_strobe = ~cpu_out.port6[6] & ~cpu_out.port6[5];

	// Port5 bits 2:1 pick the ADC input
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			adc_sel <= 2'd0;
		end else if (sel_strobe) begin
			adc_sel <= cpu_out.port5[2:1];
		end
	end

	always_comb begin
		case (adc_sel)
			2'd0:    analog_byte = pl2.gas;
			2'd1:    analog_byte = pl1.gas;
			2'd2:    analog_byte = pl2.steering;
			default: analog_byte = pl1.steering;
		endcase
	end

endmodule

//--- gearbox/gear_tracker.sv
// Max RPM gears and Power Drive toggles step on button rises; all gear state clears a cycle after game changes
`timescale 1ns/1ps

module gear_tracker (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  mcr3_input_pkg::game_e       game,
	input  mcr3_input_pkg::player_t     p1,
	input  mcr3_input_pkg::player_t     p2,
	input  mcr3_input_pkg::player_t     p3,
	input  mcr3_input_pkg::cabinet_t    cabinet,
	output mcr3_input_pkg::gear_state_t gears
);

	logic [2:0]            gear1;
	logic [2:0]            gear2;
	logic [2:0]            pd_gear;
	logic [1:0]            rpm_last1;
	logic [1:0]            rpm_last2;
	logic [2:0]            pd_last;
	mcr3_input_pkg::game_e game_q;
	logic                  game_change;
	logic                  up1;
	logic                  down1;
	logic                  up2;
	logic                  down2;
	logic [2:0]            pd_rise;

	// ============================================================
	// Edge detect against last cycle's buttons
	// ============================================================

	assign up1     = p1.fire_a & ~rpm_last1[0];
	assign down1   = p1.fire_b & ~rpm_last1[1];
	assign up2     = p2.fire_a & ~rpm_last2[0];
	assign down2   = p2.fire_b & ~rpm_last2[1];
	assign pd_rise = {p3.fire_d, p2.fire_d, p1.fire_d} & ~pd_last;

	assign game_change = (game != game_q);

	// ============================================================
	// Gear registers
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gear1     <= 3'd0;
			gear2     <= 3'd0;
			pd_gear   <= 3'd0;
			rpm_last1 <= 2'b00;
			rpm_last2 <= 2'b00;
			pd_last   <= 3'b000;
			game_q    <= game;
		end else begin
			rpm_last1 <= {p1.fire_b, p1.fire_a};
			rpm_last2 <= {p2.fire_b, p2.fire_a};
			pd_last   <= {p3.fire_d, p2.fire_d, p1.fire_d};
			game_q    <= game;

			// Start drops the shifter back to neutral
			if (game_change || cabinet.start1) begin
				gear1 <= 3'd0;
			end else if (up1 && gear1 != mcr3_input_pkg::max_gear) begin
				gear1 <= gear1 + 3'd1;
			end else if (down1 && gear1 != 3'd0) begin
				gear1 <= gear1 - 3'd1;
			end

			if (game_change || cabinet.start2) begin
				gear2 <= 3'd0;
			end else if (up2 && gear2 != mcr3_input_pkg::max_gear) begin
				gear2 <= gear2 + 3'd1;
			end else if (down2 && gear2 != 3'd0) begin
				gear2 <= gear2 - 3'd1;
			end

			// Power Drive has a two-position shifter per player
			if (game_change) begin
				pd_gear <= 3'd0;
			end else begin
				pd_gear <= pd_gear ^ pd_rise;
			end
		end
	end

	assign gears = {gear1, gear2, pd_gear, 7'd0};

	// The packer indexes gear_code with these, so they must stay in table range
	assert property (@(posedge clk_sys) disable iff (reset)
		gears.gear1 <= mcr3_input_pkg::max_gear && gears.gear2 <= mcr3_input_pkg::max_gear)
		else $error("gear out of range gear1=%0d gear2=%0d", gears.gear1, gears.gear2);

endmodule

//--- verilog/cabinet_port_pack.sv
// Per-game input port layouts, registered once; port3 carries no controls and always reads 0xFF
`timescale 1ns/1ps

module cabinet_port_pack (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  mcr3_input_pkg::game_e         game,
	input  mcr3_input_pkg::player_t [3:0] player,
	input  mcr3_input_pkg::cabinet_t      cabinet,
	input  mcr3_input_pkg::gear_state_t   gears,
	input  logic [7:0]                    analog_byte,
	input  logic [1:0]                    snd_stat,
	output mcr3_input_pkg::in_ports_t     ports
);

	mcr3_input_pkg::player_t   p1;
	mcr3_input_pkg::player_t   p2;
	mcr3_input_pkg::player_t   p3;
	mcr3_input_pkg::player_t   p4;
	mcr3_input_pkg::in_ports_t raw;
	logic [3:0]                code1;
	logic [3:0]                code2;

	assign p1 = player[0];
	assign p2 = player[1];
	assign p3 = player[2];
	assign p4 = player[3];

	assign code1 = mcr3_input_pkg::gear_code[gears.gear1];
	assign code2 = mcr3_input_pkg::gear_code[gears.gear2];

	// ============================================================
	// Layouts, active high here and inverted at the register
	// ============================================================

	always_comb begin
		raw = '0;
		case (game)
			mcr3_input_pkg::sarge: begin
				// Twin sticks, each fire pair shares one switch
				raw.port0 = {2'b00, cabinet.service, 1'b0,
					cabinet.start2, cabinet.start1, cabinet.coin2, cabinet.coin1};
				raw.port1 = {p1.fire_a | p1.fire_b, p1.fire_a | p1.fire_b,
					p2.fire_a | p2.fire_b, p2.fire_a | p2.fire_b,
					p1.down, p1.up, p1.down, p1.up};
				raw.port2 = {p3.fire_a | p3.fire_b, p3.fire_a | p3.fire_b,
					p4.fire_a | p4.fire_b, p4.fire_a | p4.fire_b,
					p3.down, p3.up, p4.down, p4.up};
			end
			mcr3_input_pkg::max_rpm: begin
				raw.port0 = {cabinet.service, 3'b000,
					cabinet.start1, cabinet.start2, cabinet.coin1, cabinet.coin2};
				// Pedal or wheel reading chosen by the CPU
				raw.port1 = analog_byte;
				raw.port2 = {code1, code2};
			end
			mcr3_input_pkg::rampage: begin
				raw.port0 = {2'b00, cabinet.service, 1'b0,
					2'b00, cabinet.coin2, cabinet.coin1};
				raw.port1 = {2'b00, p1.fire_b, p1.fire_a,
					p1.left, p1.down, p1.right, p1.up};
				raw.port2 = {2'b00, p2.fire_b, p2.fire_a,
					p2.left, p2.down, p2.right, p2.up};
				raw.port4 = {2'b00, p3.fire_b, p3.fire_a,
					p3.left, p3.down, p3.right, p3.up};
			end
			default: begin
				// Power Drive, three players on buttons only
				raw.port0 = {2'b00, cabinet.service, 1'b0,
					1'b0, cabinet.coin3, cabinet.coin2, cabinet.coin1};
				raw.port1 = {p2.fire_b, p2.fire_a, gears.pd_gear[1], p2.fire_c,
					p1.fire_b, p1.fire_a, gears.pd_gear[0], p1.fire_c};
				raw.port2 = {snd_stat[0], 3'b000,
					p3.fire_b, p3.fire_a, gears.pd_gear[2], p3.fire_c};
			end
		endcase
	end

	// ============================================================
	// Output register
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ports <= '1;
		end else begin
			ports <= ~raw;
		end
	end

endmodule

//--- verilog/mcr3_input_top.sv
// MCR3 cabinet inputs; player[0] is player 1, vsync is a level sampled on clk_sys, ports are active low
`timescale 1ns/1ps

module mcr3_input_top (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  mcr3_input_pkg::game_e               game,
	input  mcr3_input_pkg::player_t [3:0]       player,
	input  mcr3_input_pkg::cabinet_t            cabinet,
	input  mcr3_input_pkg::out_latch_t          cpu_out,
	input  logic [1:0]                          snd_stat,
	input  logic                                vsync,
	output mcr3_input_pkg::in_ports_t           ports
);

	mcr3_input_pkg::analog_t     analog_p1;
	mcr3_input_pkg::analog_t     analog_p2;
	mcr3_input_pkg::gear_state_t gears;
	logic [7:0]                  analog_byte;

	// ============================================================
	// Max RPM pedals and wheels
	// ============================================================

	pedal_steer_ramp ramp_p1 (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vsync   (vsync),
		.ctrl    (player[0]),
		.analog  (analog_p1)
	);

	pedal_steer_ramp ramp_p2 (
		.clk_sys (clk_sys),
		.reset   (reset),
		.vsync   (vsync),
		.ctrl    (player[1]),
		.analog  (analog_p2)
	);

	// ADC channel picked by the CPU
	analog_select analog_sel (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu_out     (cpu_out),
		.pl1         (analog_p1),
		.pl2         (analog_p2),
		.analog_byte (analog_byte)
	);

	// ============================================================
	// Gears and port packing
	// ============================================================

	gear_tracker gearbox (
		.clk_sys (clk_sys),
		.reset   (reset),
		.game    (game),
		.p1      (player[0]),
		.p2      (player[1]),
		.p3      (player[2]),
		.cabinet (cabinet),
		.gears   (gears)
	);

	cabinet_port_pack port_pack (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.game        (game),
		.player      (player),
		.cabinet     (cabinet),
		.gears       (gears),
		.analog_byte (analog_byte),
		.snd_stat    (snd_stat),
		.ports       (ports)
	);

endmodule

//--- verif/tb_mcr3_input.sv
// Runs verif/mcr3_input_stim.txt from the project root; the run stops at the first mismatching port
`timescale 1ns/1ps

module tb_mcr3_input;

	localparam stim_path = "verif/mcr3_input_stim.txt";

	logic                          clk_sys;
	logic                          reset;
	mcr3_input_pkg::game_e         game;
	mcr3_input_pkg::player_t [3:0] player;
	mcr3_input_pkg::cabinet_t      cabinet;
	mcr3_input_pkg::out_latch_t    cpu_out;
	logic [1:0]                    snd_stat;
	logic                          vsync;
	mcr3_input_pkg::in_ports_t     ports;
	int                            cycle_count = 0;
	int                            cycle_limit = 200;
	int                            checks_done = 0;

	mcr3_input_top i_mcr3_input_top (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.game     (game),
		.player   (player),
		.cabinet  (cabinet),
		.cpu_out  (cpu_out),
		.snd_stat (snd_stat),
		.vsync    (vsync),
		.ports    (ports)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#20 clk_sys = ~clk_sys;
		end
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped");
	endtask

	// Limit comes from the stim file's cycle counts
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			abort_run($sformatf("Timeout, the run went past %0d cycles", cycle_limit));
		end
	end

	// ============================================================
	// Drive and check helpers
	// ============================================================

	// Returns 2 ns after a rising edge, where inputs change
	task automatic run_cycles(input int count);
		repeat (count) begin
			@(posedge clk_sys);
			#2;
		end
	endtask

	task automatic pulse_vsync(input int count);
		repeat (count) begin
			vsync = 1'b1;
			run_cycles(1);
			vsync = 1'b0;
			run_cycles(1);
		end
	endtask

	task automatic skip_line(input int fd);
		int ch;
		ch = 0;
		while (ch != 10 && ch != -1) begin
			ch = $fgetc(fd);
		end
	endtask

	task automatic require_fields(input int got, input int need);
		if (got != need) begin
			abort_run("A stim file line has the wrong number of fields");
		end
	endtask

	task automatic check_port_byte(input int idx, input logic [7:0] expected);
		logic [7:0] actual;
		actual = ports[8 * (4 - idx) +: 8];
		if (actual !== expected) begin
			abort_run($sformatf("ERROR ports.port%0d expected 0x%02h actual 0x%02h",
				idx, expected, actual));
		end
		checks_done++;
	endtask

	task automatic check_ports(input mcr3_input_pkg::in_ports_t expected);
		for (int idx = 0; idx < 5; idx++) begin
			check_port_byte(idx, expected[8 * (4 - idx) +: 8]);
		end
	endtask

	// ============================================================
	// Stim file, a dry pass only sums the cycle counts
	// ============================================================

	task automatic run_stim(input bit dry, output int cycles);
		logic [63:0] word;
		logic [31:0] field [0:10];
		logic [31:0] rnd;
		int          got;
		int          fd;
		cycles = 0;
		fd = $fopen(stim_path, "r");
		if (fd == 0) begin
			abort_run("Cannot open the stim file verif/mcr3_input_stim.txt");
		end
		while ($fscanf(fd, "%s", word) == 1) begin
			if (word == "#") begin
				skip_line(fd);
			end else if (word == "set") begin
				got = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h",
					field[0], field[1], field[2], field[3], field[4], field[5],
					field[6], field[7], field[8], field[9], field[10]);
				require_fields(got, 11);
				cycles += field[10];
				if (!dry) begin
					game = mcr3_input_pkg::game_e'(field[0][1:0]);
					// Masked players are unused by this game and get noise
					for (int idx = 0; idx < 4; idx++) begin
						rnd = $urandom;
						player[idx] = field[9][idx] ? rnd[7:0] : field[idx + 1][7:0];
					end
					cabinet       = field[5][7:0];
					cpu_out.port5 = field[6][7:0];
					cpu_out.port6 = field[7][7:0];
					snd_stat      = field[8][1:0];
					run_cycles(field[10]);
				end
			end else if (word == "wait" || word == "vsync") begin
				got = $fscanf(fd, "%d", field[0]);
				require_fields(got, 1);
				cycles += field[0];
				if (!dry && word == "wait") begin
					run_cycles(field[0]);
				end else if (!dry) begin
					pulse_vsync(field[0]);
				end
			end else if (word == "expect") begin
				got = $fscanf(fd, "%h %h %h %h %h",
					field[0], field[1], field[2], field[3], field[4]);
				require_fields(got, 5);
				if (!dry) begin
					check_ports({field[0][7:0], field[1][7:0], field[2][7:0],
						field[3][7:0], field[4][7:0]});
				end
			end else if (word == "byte") begin
				got = $fscanf(fd, "%d %h", field[0], field[1]);
				require_fields(got, 2);
				if (!dry) begin
					check_port_byte(field[0], field[1][7:0]);
				end
			end else begin
				abort_run($sformatf("Unknown command %0s in the stim file", word));
			end
		end
		$fclose(fd);
	endtask

	initial begin
		int total;
		void'($urandom(94));
		reset         = 1'b1;
		game          = mcr3_input_pkg::sarge;
		player        = '0;
		cabinet       = '0;
		cpu_out.port5 = 8'h00;
		cpu_out.port6 = 8'h60;
		snd_stat      = 2'b00;
		vsync         = 1'b0;
		run_stim(1'b1, total);
		cycle_limit = total * 2 + 200;
		run_cycles(10);
		reset = 1'b0;
		run_stim(1'b0, total);
		if (checks_done > 0) begin
			$display("%0d port bytes matched", checks_done);
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			abort_run("The stim file ran no checks");
		end
	end

endmodule

//--- verif/mcr3_input_stim.txt
# set: game p1 p2 p3 p4 cabinet port5 port6 snd_stat random_mask cycles, all hex
# vsync and wait: count; expect: port0 to port4 in hex; byte: index and hex value
expect ff ff ff ff ff
# Sarge, ports follow one cycle later
set 0 88 44 80 48 90 00 60 0 0 0
expect ff ff ff ff ff
wait 1
expect fa 0a c9 ff ff
# Rampage with player 3 on port4
set 2 88 24 58 00 44 00 60 0 8 1
expect dd ee d7 ff e9
# Max RPM gearbox for player 1
set 1 00 00 00 00 00 00 60 0 c 2
expect ff ff ff ff ff
set 1 08 00 00 00 00 00 60 0 c 2
byte 2 af
set 1 00 00 00 00 00 00 60 0 c 1
set 1 08 00 00 00 00 00 60 0 c 1
set 1 00 00 00 00 00 00 60 0 c 1
set 1 08 00 00 00 00 00 60 0 c 1
set 1 00 00 00 00 00 00 60 0 c 1
set 1 08 00 00 00 00 00 60 0 c 1
set 1 00 00 00 00 00 00 60 0 c 1
set 1 08 00 00 00 00 00 60 0 c 1
set 1 00 00 00 00 00 00 60 0 c 1
byte 2 df
set 1 08 00 00 00 00 00 60 0 c 1
set 1 00 00 00 00 00 00 60 0 c 1
byte 2 df
set 1 04 00 00 00 00 00 60 0 c 1
set 1 00 00 00 00 00 00 60 0 c 1
byte 2 ef
set 1 00 00 00 00 10 00 60 0 c 2
expect f7 ff ff ff ff
# Max RPM ramps, channel 1 is player 1 gas
set 1 80 00 00 00 00 02 00 0 c 1
set 1 80 00 00 00 00 02 60 0 c 1
byte 1 ff
vsync 3
wait 1
byte 1 e7
wait 5
byte 1 e7
# Channel 3 is player 1 steering
set 1 10 00 00 00 00 06 00 0 c 1
set 1 10 00 00 00 00 06 60 0 c 1
byte 1 7f
vsync 20
wait 1
byte 1 00
# Channels 0 and 2 are player 2
set 1 00 00 00 00 00 00 00 0 c 1
set 1 00 00 00 00 00 00 60 0 c 1
byte 1 ff
set 1 00 00 00 00 00 04 00 0 c 1
set 1 00 00 00 00 00 04 60 0 c 1
byte 1 7f
# No write while a select bit is high
set 1 00 00 00 00 00 02 40 0 c 2
byte 1 7f
set 1 00 00 00 00 00 02 9f 0 c 1
set 1 00 00 00 00 00 02 60 0 c 1
byte 1 e7
# Power Drive gear toggles
set 3 00 00 00 00 00 00 60 0 8 2
expect ff ff ff ff ff
set 3 01 00 00 00 00 00 60 0 8 2
byte 1 fd
set 3 01 00 00 00 00 00 60 0 8 3
byte 1 fd
set 3 01 01 01 00 00 00 60 1 8 2
expect ff dd 7d ff ff
set 3 00 00 00 00 20 00 60 0 8 1
set 3 01 00 00 00 20 00 60 0 8 2
expect fb df fd ff ff

//--- vlog.f
common/mcr3_input_pkg.sv
analog_control/pedal_steer_ramp.sv
analog_control/analog_select.sv
gearbox/gear_tracker.sv
verilog/cabinet_port_pack.sv
verilog/mcr3_input_top.sv
verif/tb_mcr3_input.sv

//--- Bender.yml
package:
  name: mcr3_input

sources:
  - common/mcr3_input_pkg.sv
  - analog_control/pedal_steer_ramp.sv
  - analog_control/analog_select.sv
  - gearbox/gear_tracker.sv
  - verilog/cabinet_port_pack.sv
  - verilog/mcr3_input_top.sv
  - target: test
    files:
      - verif/tb_mcr3_input.sv
